// ==== include/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// ******************************
// core build constants
// ******************************

// first fetch after reset.
`define RV_RESET_ADDR 32'h0000_0000

// data and address width.
`define RV_XLEN 32

// architectural registers, x0 included.
`define RV_NUM_REGS 32

`endif

// ==== rtl/rv_alu.sv ====
`default_nettype none

module rv_alu
(
    input  wire rv_pkg::alu_op_t    i_op,
    input  wire rv_pkg::word_t      i_a,
    input  wire rv_pkg::word_t      i_b,
    output rv_pkg::word_t           o_result,
    output logic                    o_equal
);
    import rv_pkg::*;

    logic [4:0] w_shamt;
    logic       w_less;

    assign w_shamt = i_b[4:0];                           // low bits only.
    assign w_less  = ($signed(i_a) < $signed(i_b));

    always_comb
    begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SLT:    o_result = word_t'(w_less);
            ALU_SLL:    o_result = i_a << w_shamt;
            ALU_SRL:    o_result = i_a >> w_shamt;
            ALU_PASS_B: o_result = i_b;
            default:    o_result = '0;
        endcase
    end

    // branch compare, independent of the selected op.
    assign o_equal = (i_a == i_b);

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
`default_nettype none

`include "rv_config.svh"

module rv_core
(
    input  wire                     i_clk,
    input  wire                     i_reset_n,
    output rv_pkg::wb_req_t         o_wb_req,
    input  wire rv_pkg::word_t      i_wb_dat,
    input  wire                     i_wb_ack
);
    import rv_pkg::*;

    localparam wb_req_t WB_IDLE = '{adr: '0, dat: '0, we: 1'b0, sel: 4'hf,
                                   stb: 1'b0, cyc: 1'b0};

    stage_t         r_stage;
    stage_t         w_stage_next;
    word_t          r_pc;
    word_t          r_instr;
    word_t          r_alu_result;
    word_t          r_target;
    word_t          r_load_dat;
    logic           r_take_branch;
    wb_req_t        r_wb_req;
    wb_req_t        w_wb_req_next;
    decoded_instr_t w_dec;
    word_t          w_rs1_val;
    word_t          w_rs2_val;
    word_t          w_alu_b;
    word_t          w_alu_result;
    logic           w_alu_equal;
    logic           w_branch_cond;
    logic           w_bus_done;
    word_t          w_pc_plus4;
    word_t          w_pc_next;
    word_t          w_rd_val;

    assign w_bus_done = r_wb_req.stb && i_wb_ack;

    // ******************************
    // stage sequencing
    // ******************************

    always_comb
    begin
        case (r_stage)
            ST_FETCH:   w_stage_next = w_bus_done ? ST_DECODE : ST_FETCH;
            ST_DECODE:  w_stage_next = ST_EXECUTE;
            ST_EXECUTE: w_stage_next = (w_dec.is_load || w_dec.is_store) ? ST_MEMORY : ST_WRITE;
            ST_MEMORY:  w_stage_next = w_bus_done ? ST_WRITE : ST_MEMORY;
            ST_WRITE:   w_stage_next = ST_FETCH;
            default:    w_stage_next = ST_FETCH;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_stage <= ST_FETCH;
        end
        else
        begin
            r_stage <= w_stage_next;
        end
    end

    // ******************************
    // datapath
    // ******************************

    rv_decoder u_decoder
    (
        .i_instr   (r_instr),
        .o_dec     (w_dec)
    );

    rv_regfile u_regfile
    (
        .i_clk     (i_clk),
        .i_rs1     (w_dec.rs1),
        .i_rs2     (w_dec.rs2),
        .o_rs1_val (w_rs1_val),
        .o_rs2_val (w_rs2_val),
        .i_we      ((r_stage == ST_WRITE) && w_dec.reg_write),
        .i_rd      (w_dec.rd),
        .i_rd_val  (w_rd_val)
    );

    assign w_alu_b = w_dec.use_imm ? w_dec.imm : w_rs2_val;

    rv_alu u_alu
    (
        .i_op      (w_dec.alu_op),
        .i_a       (w_rs1_val),
        .i_b       (w_alu_b),
        .o_result  (w_alu_result),
        .o_equal   (w_alu_equal)
    );

    assign w_branch_cond = w_dec.is_branch && (w_alu_equal ^ w_dec.branch_ne);

    always_ff @(posedge i_clk)
    begin
        if ((r_stage == ST_FETCH) && w_bus_done)
        begin
            r_instr <= i_wb_dat;
        end
        if (r_stage == ST_EXECUTE)
        begin
            r_alu_result  <= w_alu_result;
            r_target      <= r_pc + w_dec.imm;           // b or j offset.
            r_take_branch <= w_branch_cond || w_dec.is_jal;
        end
        if ((r_stage == ST_MEMORY) && w_bus_done)
        begin
            r_load_dat <= i_wb_dat;
        end
    end

    assign w_pc_plus4 = r_pc + word_t'(4);
    assign w_pc_next  = r_take_branch ? r_target : w_pc_plus4;

    assign w_rd_val = w_dec.is_load ? r_load_dat :
                      w_dec.is_jal  ? w_pc_plus4 :     // link.
                      r_alu_result;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_pc <= `RV_RESET_ADDR;
        end
        else if (r_stage == ST_WRITE)
        begin
            r_pc <= w_pc_next;
        end
    end

    // ******************************
    // wishbone master
    // ******************************

    // request follows the next stage and holds until ack.
    always_comb
    begin
        w_wb_req_next = r_wb_req;
        if (!r_wb_req.stb || i_wb_ack)
        begin
            w_wb_req_next.sel = 4'hf;
            w_wb_req_next.we  = 1'b0;
            w_wb_req_next.stb = 1'b0;
            w_wb_req_next.cyc = 1'b0;
            case (w_stage_next)
                ST_FETCH:
                begin
                    w_wb_req_next.adr = (r_stage == ST_WRITE) ? w_pc_next : r_pc;
                    w_wb_req_next.dat = '0;
                    w_wb_req_next.stb = 1'b1;
                    w_wb_req_next.cyc = 1'b1;
                end
                ST_MEMORY:
                begin
                    w_wb_req_next.adr = w_alu_result;    // rs1 + offset.
                    w_wb_req_next.dat = w_rs2_val;
                    w_wb_req_next.we  = w_dec.is_store;
                    w_wb_req_next.stb = 1'b1;
                    w_wb_req_next.cyc = 1'b1;
                end
                default:
                begin
                    w_wb_req_next.we = 1'b0;             // bus idle.
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_wb_req <= WB_IDLE;
        end
        else
        begin
            r_wb_req <= w_wb_req_next;
        end
    end

    assign o_wb_req = r_wb_req;

endmodule

`default_nettype wire

// ==== rtl/rv_decoder.sv ====
`default_nettype none

module rv_decoder
(
    input  wire rv_pkg::word_t          i_instr,
    output rv_pkg::decoded_instr_t      o_dec
);
    import rv_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [6:0] w_opcode;
    logic [2:0] w_funct3;
    logic [6:0] w_funct7;
    word_t      w_imm_i;
    word_t      w_imm_s;
    word_t      w_imm_b;
    word_t      w_imm_u;
    word_t      w_imm_j;
    logic       w_alt;
    logic       w_f7_ok;
    logic       w_arith_ok;
    alu_op_t    w_arith_op;

    assign w_opcode = i_instr[6:0];
    assign w_funct3 = i_instr[14:12];
    assign w_funct7 = i_instr[31:25];

    assign w_imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign w_imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
    assign w_imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign w_imm_u = {i_instr[31:12], 12'h000};
    assign w_imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    // funct7 only carries meaning for register ops and immediate shifts.
    assign w_alt   = w_funct7[5] && ((w_opcode == OPC_OP) || (w_funct3 == 3'b101));
    assign w_f7_ok = ((w_funct7 & 7'b101_1111) == 7'd0) ||
                     ((w_opcode == OPC_OP_IMM) && (w_funct3[1:0] != 2'b01));

    always_comb
    begin
        w_arith_ok = w_f7_ok;
        case ({w_alt, w_funct3})
            4'b0_000: w_arith_op = ALU_ADD;
            4'b1_000: w_arith_op = ALU_SUB;
            4'b0_001: w_arith_op = ALU_SLL;
            4'b0_010: w_arith_op = ALU_SLT;
            4'b0_100: w_arith_op = ALU_XOR;
            4'b0_101: w_arith_op = ALU_SRL;
            4'b0_110: w_arith_op = ALU_OR;
            4'b0_111: w_arith_op = ALU_AND;
            default:
            begin
                w_arith_op = ALU_ADD;
                w_arith_ok = 1'b0;                       // sltu, sra and friends.
            end
        endcase
    end

    always_comb
    begin
        o_dec        = '0;
        o_dec.alu_op = ALU_ADD;
        o_dec.rd     = i_instr[11:7];
        o_dec.rs1    = i_instr[19:15];
        o_dec.rs2    = i_instr[24:20];
        case (w_opcode)
            OPC_OP:
            begin
                o_dec.alu_op    = w_arith_op;
                o_dec.reg_write = w_arith_ok;
            end
            OPC_OP_IMM:
            begin
                o_dec.alu_op    = w_arith_op;
                o_dec.imm       = w_imm_i;
                o_dec.use_imm   = 1'b1;
                o_dec.reg_write = w_arith_ok;
            end
            OPC_LUI:
            begin
                o_dec.alu_op    = ALU_PASS_B;
                o_dec.imm       = w_imm_u;
                o_dec.use_imm   = 1'b1;
                o_dec.reg_write = 1'b1;
            end
            OPC_LOAD:
            begin
                o_dec.imm       = w_imm_i;
                o_dec.use_imm   = 1'b1;
                o_dec.reg_write = (w_funct3 == 3'b010);  // lw only.
                o_dec.is_load   = (w_funct3 == 3'b010);
            end
            OPC_STORE:
            begin
                o_dec.imm      = w_imm_s;
                o_dec.use_imm  = 1'b1;
                o_dec.is_store = (w_funct3 == 3'b010);   // sw only.
            end
            OPC_BRANCH:
            begin
                o_dec.alu_op    = ALU_SUB;
                o_dec.imm       = w_imm_b;
                o_dec.is_branch = (w_funct3[2:1] == 2'b00);
                o_dec.branch_ne = w_funct3[0];
            end
            OPC_JAL:
            begin
                o_dec.imm       = w_imm_j;
                o_dec.reg_write = 1'b1;
                o_dec.is_jal    = 1'b1;
            end
            default:
            begin
                o_dec.imm = '0;                          // no-op.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv_pkg.sv ====
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;                 // data, address, instruction.
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;  // register index.

    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B                                       // lui result.
    } alu_op_t;

    typedef enum logic [2:0]
    {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITE
    } stage_t;

    typedef struct packed
    {
        alu_op_t  alu_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
        logic     use_imm;                               // alu b from imm.
        logic     reg_write;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        logic     branch_ne;                             // bne rather than beq.
        logic     is_jal;
    } decoded_instr_t;

    typedef struct packed
    {
        word_t      adr;
        word_t      dat;
        logic       we;
        logic [3:0] sel;
        logic       stb;
        logic       cyc;
    } wb_req_t;

endpackage

`default_nettype wire

// ==== rtl/rv_regfile.sv ====
`default_nettype none

`include "rv_config.svh"

module rv_regfile
(
    input  wire                     i_clk,
    input  wire rv_pkg::reg_idx_t   i_rs1,
    input  wire rv_pkg::reg_idx_t   i_rs2,
    output rv_pkg::word_t           o_rs1_val,
    output rv_pkg::word_t           o_rs2_val,
    input  wire                     i_we,
    input  wire rv_pkg::reg_idx_t   i_rd,
    input  wire rv_pkg::word_t      i_rd_val
);
    import rv_pkg::*;

    word_t r_regs [`RV_NUM_REGS];

    always_ff @(posedge i_clk)
    begin
        if (i_we && (i_rd != '0))
        begin
            r_regs[i_rd] <= i_rd_val;                    // x0 never written.
        end
    end

    // x0 is hardwired, its array slot is never read.
    assign o_rs1_val = (i_rs1 == '0) ? '0 : r_regs[i_rs1];
    assign o_rs2_val = (i_rs2 == '0) ? '0 : r_regs[i_rs2];

endmodule

`default_nettype wire

// ==== rv_core.f ====
+incdir+include
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_core.sv
verif/rv_wb_mem.sv
verif/rv_core_tb.sv

// ==== verif/rv_core_tb.sv ====
`default_nettype none

`include "rv_config.svh"

module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    localparam int unsigned SEED      = 32'h6c3258c9;
    localparam int          TIMEOUT   = 20000;
    localparam word_t       BASE      = 32'h0000_0400;
    localparam word_t       DONE_ADDR = BASE + 64;

    logic    clk;
    logic    reset_n;
    wb_req_t wb_req;
    word_t   wb_dat;
    logic    wb_ack;

    int      proto_errors = 0;
    int      data_errors  = 0;
    int      cycle_cnt    = 0;
    int      wait_cnt;
    logic    done_seen    = 1'b0;
    logic    expect_data  = 1'b0;
    logic    expect_store = 1'b0;
    word_t   next_fetch   = `RV_RESET_ADDR;
    word_t   pc;
    word_t   a_val;
    word_t   b_val;
    word_t   lui_val;
    word_t   exp_next   [word_t];
    word_t   exp_store  [word_t];
    bit      store_seen [word_t];

    rv_core dut0
    (
        .i_clk     (clk),
        .i_reset_n (reset_n),
        .o_wb_req  (wb_req),
        .i_wb_dat  (wb_dat),
        .i_wb_ack  (wb_ack)
    );

    rv_wb_mem #(.SEED(SEED)) mem0
    (
        .i_clk (clk),
        .i_req (wb_req),
        .o_dat (wb_dat),
        .o_ack (wb_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ******************************
    // bus protocol
    // ******************************

    a_reset_idle: assert property (@(posedge clk)
        ((cycle_cnt != 0) && !reset_n) |-> (!wb_req.cyc && !wb_req.stb && !wb_req.we))
    else
    begin
        proto_errors++;
        $display("bus not idle while reset is asserted");
    end

    a_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (wb_req.stb && !wb_ack) |=> (wb_req.stb && $stable(wb_req.adr) &&
        $stable(wb_req.dat) && $stable(wb_req.we) && $stable(wb_req.sel)))
    else
    begin
        proto_errors++;
        $display("request changed before ack");
    end

    a_sel: assert property (@(posedge clk) disable iff (!reset_n)
        wb_req.stb |-> (wb_req.sel == 4'hf))
    else
    begin
        proto_errors++;
        $display("sel not all ones during an access");
    end

    a_cyc_stb: assert property (@(posedge clk) disable iff (!reset_n)
        wb_req.cyc == wb_req.stb)
    else
    begin
        proto_errors++;
        $display("cyc and stb disagree");
    end

    a_drop: assert property (@(posedge clk) disable iff (!reset_n)
        (wb_req.stb && wb_ack) |=> (!wb_req.stb && !wb_req.cyc))
    else
    begin
        proto_errors++;
        $display("stb or cyc still high in the cycle after ack");
    end

    // ******************************
    // program and expected values
    // ******************************

    function automatic word_t rtype(input logic [6:0] f7, input int rs2, input int rs1,
                                    input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic word_t itype(input logic [11:0] imm, input int rs1,
                                    input logic [2:0] f3, input int rd, input logic [6:0] opc);
        return {imm, 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic word_t stype(input logic [11:0] imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t btype(input logic [12:0] imm, input int rs2, input int rs1,
                                    input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t jtype(input logic [20:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
    endfunction

    // places one word and the address fetched after it.
    task automatic emit(input word_t instr, input word_t step);
        mem0.write_word(pc, instr);
        exp_next[pc]  = pc + step;
        pc            = pc + 4;
    endtask

    task automatic load_program();
        int i;
        pc      = `RV_RESET_ADDR;
        a_val   = 32'd100;
        b_val   = -32'sd7;
        lui_val = {20'h12345, 12'h000};
        emit(itype(12'd100, 0, 3'b000, 1, 7'b0010011), 4);
        emit(itype(-12'sd7, 0, 3'b000, 2, 7'b0010011), 4);
        emit(itype(12'h400, 0, 3'b000, 20, 7'b0010011), 4);
        emit(rtype(7'h00, 2, 1, 3'b000, 3), 4);            // add.
        emit(rtype(7'h20, 2, 1, 3'b000, 4), 4);            // sub.
        emit(rtype(7'h00, 2, 1, 3'b111, 5), 4);
        emit(rtype(7'h00, 2, 1, 3'b110, 6), 4);
        emit(rtype(7'h00, 2, 1, 3'b100, 7), 4);
        emit(rtype(7'h00, 1, 2, 3'b010, 8), 4);            // slt x8, x2, x1.
        emit(itype(12'd3, 1, 3'b001, 9, 7'b0010011), 4);
        emit(itype(12'd4, 2, 3'b101, 10, 7'b0010011), 4);
        emit({20'h12345, 5'd11, 7'b0110111}, 4);
        emit(itype(12'h678, 11, 3'b110, 12, 7'b0010011), 4);
        exp_store[BASE + 0]  = a_val + b_val;
        exp_store[BASE + 4]  = a_val - b_val;
        exp_store[BASE + 8]  = a_val & b_val;
        exp_store[BASE + 12] = a_val | b_val;
        exp_store[BASE + 16] = a_val ^ b_val;
        exp_store[BASE + 20] = ($signed(b_val) < $signed(a_val)) ? 32'd1 : 32'd0;
        exp_store[BASE + 24] = a_val << 3;
        exp_store[BASE + 28] = b_val >> 4;
        exp_store[BASE + 32] = lui_val;
        exp_store[BASE + 36] = lui_val | 32'h0000_0678;
        for (i = 0; i < 10; i++)
        begin
            emit(stype(12'(i * 4), 3 + i, 20), 4);
        end
        emit(stype(12'd40, 12, 20), 4);
        emit(itype(12'd40, 20, 3'b010, 13, 7'b0000011), 4);  // lw.
        emit(stype(12'd44, 13, 20), 4);
        exp_store[BASE + 40] = lui_val | 32'h0000_0678;
        exp_store[BASE + 44] = lui_val | 32'h0000_0678;
        emit(itype(12'd55, 0, 3'b000, 0, 7'b0010011), 4);    // write to x0.
        emit(stype(12'd48, 0, 20), 4);
        exp_store[BASE + 48] = '0;
        emit(itype(12'd9, 0, 3'b000, 14, 7'b0010011), 4);
        emit(btype(13'd8, 1, 1, 3'b000), 8);                 // beq taken.
        emit(itype(12'd1, 0, 3'b000, 14, 7'b0010011), 4);
        emit(btype(13'd8, 1, 1, 3'b001), 4);                 // bne not taken.
        emit(itype(12'd2, 0, 3'b000, 15, 7'b0010011), 4);
        emit(btype(13'd8, 2, 1, 3'b001), 8);                 // bne taken.
        emit(itype(12'd3, 0, 3'b000, 15, 7'b0010011), 4);
        emit(stype(12'd52, 14, 20), 4);
        emit(stype(12'd56, 15, 20), 4);
        exp_store[BASE + 52] = 32'd9;
        exp_store[BASE + 56] = 32'd2;
        exp_store[BASE + 60] = pc + 4;                       // link of the jal below.
        emit(jtype(21'd8, 16), 8);
        emit(itype(12'd0, 0, 3'b000, 16, 7'b0010011), 4);
        emit(stype(12'd60, 16, 20), 4);
        emit(itype(12'h5a5, 0, 3'b000, 17, 7'b0010011), 4);
        emit(stype(12'd64, 17, 20), 4);
        exp_store[DONE_ADDR] = 32'h0000_05a5;
        emit(jtype(21'd0, 0), 0);                            // spin.
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        assert (exp == act)
        else
        begin
            data_errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // ******************************
    // bus monitor
    // ******************************

    always @(posedge clk)
    begin
        if (reset_n && wb_req.stb && wb_ack)
        begin
            if (expect_data)
            begin
                check_value("data_we", word_t'(expect_store), word_t'(wb_req.we));
                if (wb_req.we)
                begin
                    if (exp_store.exists(wb_req.adr))
                    begin
                        check_value("store_data", exp_store[wb_req.adr], wb_req.dat);
                        store_seen[wb_req.adr] = 1'b1;
                        if (wb_req.adr == DONE_ADDR)
                        begin
                            done_seen = 1'b1;
                        end
                    end
                    else
                    begin
                        data_errors++;
                        $display("store to unexpected address %h", wb_req.adr);
                    end
                end
                expect_data = 1'b0;
            end
            else
            begin
                check_value("fetch_we", '0, word_t'(wb_req.we));
                check_value("fetch_addr", next_fetch, wb_req.adr);
                if (((wb_dat[6:0] == 7'b1100011) || (wb_dat[6:0] == 7'b1101111)) &&
                    exp_next.exists(wb_req.adr))
                begin
                    next_fetch = exp_next[wb_req.adr];       // branch or jal.
                end
                else
                begin
                    next_fetch = wb_req.adr + 4;
                end
                expect_data  = (wb_dat[6:0] == 7'b0000011) || (wb_dat[6:0] == 7'b0100011);
                expect_store = (wb_dat[6:0] == 7'b0100011);
            end
        end
    end

    initial
    begin
        reset_n = 1'b0;
        @(posedge clk);
        load_program();
        repeat (3) @(posedge clk);
        #1 reset_n = 1'b1;
        for (wait_cnt = 0; (wait_cnt < TIMEOUT) && !done_seen; wait_cnt++)
        begin
            @(posedge clk);
        end
        if (!done_seen)
        begin
            data_errors++;
            $display("timeout waiting for the final store to the done address");
        end
        foreach (exp_store[adr])
        begin
            if (!store_seen.exists(adr))
            begin
                data_errors++;
                $display("no store seen at address %h", adr);
            end
        end
        $display("protocol errors: %0d, data errors: %0d", proto_errors, data_errors);
        if ((proto_errors + data_errors) == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/rv_wb_mem.sv ====
`default_nettype none

module rv_wb_mem
#(
    parameter int unsigned SEED  = 1,
    parameter int          DEPTH = 1024
)
(
    input  wire                     i_clk,
    input  wire rv_pkg::wb_req_t    i_req,
    output rv_pkg::word_t           o_dat,
    output logic                    o_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    word_t       r_mem [DEPTH];
    int unsigned r_wait;
    logic        r_ack_next;
    word_t       r_dat_next;
    int          r_idx;

    // word index, upper address bits alias.
    function automatic int word_index(input word_t adr);
        return int'((adr >> 2) % DEPTH);
    endfunction

    task automatic write_word(input word_t adr, input word_t dat);
        r_mem[word_index(adr)] = dat;
    endtask

    initial
    begin
        for (r_idx = 0; r_idx < DEPTH; r_idx++)
        begin
            r_mem[r_idx] = 32'hdead_beef ^ word_t'(r_idx * 4);  // depends on address.
        end
        o_ack  = 1'b0;
        o_dat  = '0;
        r_wait = $urandom(SEED) % 4;
        forever
        begin
            @(posedge i_clk);
            r_ack_next = 1'b0;
            r_dat_next = o_dat;
            if (o_ack)
            begin
                r_wait = $urandom % 4;                   // next access wait states.
            end
            else if (i_req.cyc && i_req.stb)
            begin
                if (r_wait == 0)
                begin
                    r_ack_next = 1'b1;
                    if (i_req.we)
                    begin
                        r_mem[word_index(i_req.adr)] = i_req.dat;
                    end
                    else
                    begin
                        r_dat_next = r_mem[word_index(i_req.adr)];
                    end
                end
                else
                begin
                    r_wait--;
                end
            end
            #1;
            o_ack = r_ack_next;
            o_dat = r_dat_next;
        end
    end

endmodule

`default_nettype wire
